// File: src/hdc_pkg.sv
package hdc_pkg;

    // hypervector and instruction geometry
    localparam int vec_width = 64;
    localparam int inst_w = 16;
    localparam int opcode_w = 4;
    localparam int item_aw = 6;
    localparam int shift_w = 6;
    localparam int rsvd_w = inst_w - opcode_w - item_aw;

    // bundling counters, signed and saturating at +/-15
    localparam int cnt_w = 5;
    localparam logic signed [cnt_w-1:0] cnt_max = 15;
    localparam logic signed [cnt_w-1:0] cnt_min = -15;
    localparam logic signed [cnt_w-1:0] cnt_step = 1;

    // xorshift64 generator
    localparam logic [vec_width-1:0] xs_seed = 64'h9e37_79b9_7f4a_7c15;
    localparam int xs_a = 13;
    localparam int xs_b = 7;
    localparam int xs_c = 17;

    typedef enum logic [opcode_w-1:0] {
        op_nop    = 4'd0,
        op_gen    = 4'd1,
        op_load   = 4'd2,
        op_wb     = 4'd3,
        op_move   = 4'd4,
        op_perm   = 4'd5,
        op_xor    = 4'd6,
        op_bundle = 4'd7,
        op_sign   = 4'd8,
        op_store  = 4'd9,
        op_last   = 4'd10
    } opcode_e;

    // address form: gen, load, wb
    typedef struct packed {
        logic [opcode_w-1:0] opcode;
        logic [rsvd_w-1:0]   rsvd;
        logic [item_aw-1:0]  addr;
    } inst_mem_t;

    // shift-amount form: perm
    typedef struct packed {
        logic [opcode_w-1:0] opcode;
        logic [rsvd_w-1:0]   rsvd;
        logic [shift_w-1:0]  amount;
    } inst_perm_t;

    // one host word, read either way
    typedef union packed {
        inst_mem_t  mem;
        inst_perm_t perm;
    } inst_t;

    typedef struct packed {
        logic               valid;
        opcode_e            opcode;
        logic [item_aw-1:0] addr;
        logic [shift_w-1:0] amount;
    } exec_op_t;

    typedef struct packed {
        logic                 rd_en;
        logic                 wr_en;
        logic                 gen_en;
        logic [item_aw-1:0]   addr;
        logic [vec_width-1:0] wdata;
    } mem_req_t;

endpackage

// File: src/hdc_decode.sv
module hdc_decode (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [hdc_pkg::inst_w-1:0]    wb_dat_w,
    input  logic                          busy,
    output logic                          wb_ack,
    output hdc_pkg::exec_op_t             op
);

    hdc_pkg::inst_t   word;
    hdc_pkg::opcode_e dec_opcode;
    logic             can_accept;

    assign word = wb_dat_w;

    // codes past op_last are treated as nop
    always_comb begin
        if (word.mem.opcode > hdc_pkg::opcode_w'(hdc_pkg::op_last)) begin
            dec_opcode = hdc_pkg::op_nop;
        end else begin
            dec_opcode = hdc_pkg::opcode_e'(word.mem.opcode);
        end
    end

    // one instruction in flight at a time
    assign can_accept = wb_cyc && wb_stb && !wb_ack && !busy && !op.valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= can_accept;
        end
    end

    // word is still held by the host during the ack cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            op.valid <= 1'b0;
        end else begin
            // reads are acked but dropped
            op.valid <= wb_ack && wb_we;
        end
        if (wb_ack) begin
            op.opcode <= dec_opcode;
            op.addr   <= word.mem.addr;
            op.amount <= word.perm.amount;
        end
    end

    // classic single-beat handshake
    ack_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack
    );

    // busy from execute must hold back issue
    no_issue_when_busy: assert property (
        @(posedge clk) disable iff (reset)
        $rose(op.valid) |-> !busy
    );

endmodule

// File: src/hdc_item_memory.sv
module hdc_item_memory (
    input  logic                             clk,
    input  logic                             reset,
    input  hdc_pkg::mem_req_t                req,
    output logic [hdc_pkg::vec_width-1:0]    rd_data
);

    logic [hdc_pkg::vec_width-1:0] mem [2**hdc_pkg::item_aw];
    logic [hdc_pkg::vec_width-1:0] xs_state;
    logic [hdc_pkg::vec_width-1:0] xs_s1;
    logic [hdc_pkg::vec_width-1:0] xs_s2;
    logic [hdc_pkg::vec_width-1:0] xs_next;

    // xorshift64 step, three folds
    always_comb begin
        xs_s1   = xs_state ^ (xs_state << hdc_pkg::xs_a);
        xs_s2   = xs_s1 ^ (xs_s1 >> hdc_pkg::xs_b);
        xs_next = xs_s2 ^ (xs_s2 << hdc_pkg::xs_c);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            xs_state <= hdc_pkg::xs_seed;
        end else if (req.gen_en) begin
            xs_state <= xs_next;
        end
    end

    // gen writes the advanced state, not the current one
    always_ff @(posedge clk) begin
        if (req.wr_en) begin
            mem[req.addr] <= req.wdata;
        end else if (req.gen_en) begin
            mem[req.addr] <= xs_next;
        end
    end

    // registered read, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (req.rd_en) begin
            rd_data <= mem[req.addr];
        end
    end

    no_write_with_gen: assert property (
        @(posedge clk) disable iff (reset)
        !(req.wr_en && req.gen_en)
    );

endmodule

// File: src/hdc_execute.sv
module hdc_execute (
    input  logic                             clk,
    input  logic                             reset,
    input  hdc_pkg::exec_op_t                op,
    input  logic [hdc_pkg::vec_width-1:0]    mem_rd_data,
    input  logic                             result_full,
    output hdc_pkg::mem_req_t                mem_req,
    output logic                             busy,
    output logic                             push,
    output logic [hdc_pkg::vec_width-1:0]    push_data,
    output logic                             last_pulse
);

    logic [hdc_pkg::vec_width-1:0]     reg_a;
    logic [hdc_pkg::vec_width-1:0]     reg_b;
    logic signed [hdc_pkg::cnt_w-1:0]  cnt [hdc_pkg::vec_width];
    logic signed [hdc_pkg::cnt_w-1:0]  cnt_next [hdc_pkg::vec_width];
    logic [hdc_pkg::vec_width-1:0]     sign_vec;
    logic [2*hdc_pkg::vec_width-1:0]   perm_dbl;
    logic [hdc_pkg::vec_width-1:0]     perm_vec;
    logic                              load_wait;

    // rotate left, upper half of the doubled word
    assign perm_dbl = {reg_b, reg_b} << op.amount;
    assign perm_vec = perm_dbl[2*hdc_pkg::vec_width-1 -: hdc_pkg::vec_width];

    // saturating vote per bit, and majority with ties to 0
    always_comb begin
        for (int i = 0; i < hdc_pkg::vec_width; i++) begin
            cnt_next[i] = cnt[i];
            if (reg_b[i] && cnt[i] != hdc_pkg::cnt_max) begin
                cnt_next[i] = cnt[i] + hdc_pkg::cnt_step;
            end else if (!reg_b[i] && cnt[i] != hdc_pkg::cnt_min) begin
                cnt_next[i] = cnt[i] - hdc_pkg::cnt_step;
            end
            sign_vec[i] = !cnt[i][hdc_pkg::cnt_w-1] && (cnt[i] != '0);
        end
    end

    // memory side of gen, wb and load
    always_comb begin
        mem_req       = '0;
        mem_req.addr  = op.addr;
        mem_req.wdata = reg_b;
        if (op.valid) begin
            mem_req.rd_en  = (op.opcode == hdc_pkg::op_load);
            mem_req.wr_en  = (op.opcode == hdc_pkg::op_wb);
            mem_req.gen_en = (op.opcode == hdc_pkg::op_gen);
        end
    end

    assign push       = op.valid && (op.opcode == hdc_pkg::op_store);
    assign push_data  = reg_b;
    assign last_pulse = op.valid && (op.opcode == hdc_pkg::op_last);

    // full result buffer also holds off the host
    assign busy = load_wait || result_full;

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_a     <= '0;
            reg_b     <= '0;
            cnt       <= '{default: '0};
            load_wait <= 1'b0;
        end else begin
            load_wait <= op.valid && (op.opcode == hdc_pkg::op_load);
            // second edge of a load
            if (load_wait) begin
                reg_b <= mem_rd_data;
            end
            if (op.valid) begin
                case (op.opcode)
                    hdc_pkg::op_move:   reg_a <= reg_b;
                    hdc_pkg::op_perm:   reg_b <= perm_vec;
                    hdc_pkg::op_xor:    reg_b <= reg_a ^ reg_b;
                    hdc_pkg::op_bundle: cnt <= cnt_next;
                    hdc_pkg::op_sign: begin
                        reg_b <= sign_vec;
                        cnt   <= '{default: '0};
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // decode must not issue a store into a full buffer
    no_push_when_full: assert property (
        @(posedge clk) disable iff (reset)
        push |-> !result_full
    );

endmodule

// File: src/hdc_result.sv
module hdc_result (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             push,
    input  logic [hdc_pkg::vec_width-1:0]    push_data,
    input  logic                             last_pulse,
    input  logic                             result_ready,
    output logic                             result_full,
    output logic                             result_valid,
    output logic [hdc_pkg::vec_width-1:0]    result_data,
    output logic                             last
);

    // entry frees up on the same edge it is taken
    assign result_full = result_valid && !result_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            last         <= 1'b0;
        end else begin
            last <= last_pulse;
            if (push) begin
                result_valid <= 1'b1;
            end else if (result_ready) begin
                result_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            result_data <= push_data;
        end
    end

    // stalled data must hold until taken
    data_stable_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        (result_valid && !result_ready) |=> $stable(result_data)
    );

endmodule

// File: src/hdc_core.sv
module hdc_core (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [hdc_pkg::inst_w-1:0]       wb_dat_w,
    output logic                             wb_ack,
    input  logic                             result_ready,
    output logic                             result_valid,
    output logic [hdc_pkg::vec_width-1:0]    result_data,
    output logic                             last
);

    hdc_pkg::exec_op_t             op;
    hdc_pkg::mem_req_t             mem_req;
    logic [hdc_pkg::vec_width-1:0] mem_rd_data;
    logic                          busy;
    logic                          push;
    logic [hdc_pkg::vec_width-1:0] push_data;
    logic                          last_pulse;
    logic                          result_full;

    hdc_decode i_hdc_decode (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_dat_w (wb_dat_w),
        .busy     (busy),
        .wb_ack   (wb_ack),
        .op       (op)
    );

    hdc_item_memory i_hdc_item_memory (
        .clk     (clk),
        .reset   (reset),
        .req     (mem_req),
        .rd_data (mem_rd_data)
    );

    hdc_execute i_hdc_execute (
        .clk         (clk),
        .reset       (reset),
        .op          (op),
        .mem_rd_data (mem_rd_data),
        .result_full (result_full),
        .mem_req     (mem_req),
        .busy        (busy),
        .push        (push),
        .push_data   (push_data),
        .last_pulse  (last_pulse)
    );

    hdc_result i_hdc_result (
        .clk          (clk),
        .reset        (reset),
        .push         (push),
        .push_data    (push_data),
        .last_pulse   (last_pulse),
        .result_ready (result_ready),
        .result_full  (result_full),
        .result_valid (result_valid),
        .result_data  (result_data),
        .last         (last)
    );

endmodule

// File: dv/hdc_core_tb.sv
module hdc_core_tb;

    localparam int timeout_cycles = 500;

    logic                            clk = 1'b0;
    logic                            reset;
    logic                            wb_cyc;
    logic                            wb_stb;
    logic                            wb_we;
    logic [hdc_pkg::inst_w-1:0]      wb_dat_w;
    logic                            wb_ack;
    logic                            result_ready = 1'b0;
    logic                            result_valid;
    logic [hdc_pkg::vec_width-1:0]   result_data;
    logic                            last;

    // reference copies of the core state
    logic [63:0] model_mem [64];
    logic [63:0] model_a;
    logic [63:0] model_b;
    logic [63:0] model_xs;
    int          model_cnt [64];

    logic [63:0] expected_q [$];
    logic [63:0] held_data;
    logic        stalled = 1'b0;
    integer      seed = 90429;
    integer      rnd;
    int          mismatch_count = 0;
    int          other_count = 0;
    int          stores_issued = 0;
    int          accepted_count = 0;
    int          last_count = 0;

    hdc_core i_hdc_core (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_dat_w     (wb_dat_w),
        .wb_ack       (wb_ack),
        .result_ready (result_ready),
        .result_valid (result_valid),
        .result_data  (result_data),
        .last         (last)
    );

    always #10 clk = ~clk;

    // sink accepts at random
    always begin
        @(posedge clk);
        #1;
        rnd = $random(seed);
        result_ready = rnd[0];
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic print_summary();
        $display("summary: %0d mismatches, %0d other errors, %0d results checked",
                 mismatch_count, other_count, accepted_count);
    endtask

    task automatic fail_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        other_count++;
        print_summary();
        $display("Simulation failed");
        $finish;
    endtask

    // applies one instruction to the model, returns 1 for a store
    function automatic logic hdc_model_step(input logic [15:0] word,
                                            output logic [63:0] stored);
        logic [3:0] opc;
        logic [5:0] field;
        logic [5:0] bi;
        logic       is_store;
        opc      = word[15:12];
        field    = word[5:0];
        stored   = '0;
        is_store = 1'b0;
        case (opc)
            hdc_pkg::op_gen: begin
                model_xs = model_xs ^ (model_xs << 13);
                model_xs = model_xs ^ (model_xs >> 7);
                model_xs = model_xs ^ (model_xs << 17);
                model_mem[field] = model_xs;
            end
            hdc_pkg::op_load: model_b = model_mem[field];
            hdc_pkg::op_wb:   model_mem[field] = model_b;
            hdc_pkg::op_move: model_a = model_b;
            hdc_pkg::op_perm: model_b = (model_b << field) | (model_b >> (64 - int'(field)));
            hdc_pkg::op_xor:  model_b = model_a ^ model_b;
            hdc_pkg::op_bundle: begin
                for (int i = 0; i < 64; i++) begin
                    bi = 6'(i);
                    if (model_b[bi]) begin
                        if (model_cnt[bi] < 15) model_cnt[bi] = model_cnt[bi] + 1;
                    end else if (model_cnt[bi] > -15) begin
                        model_cnt[bi] = model_cnt[bi] - 1;
                    end
                end
            end
            hdc_pkg::op_sign: begin
                // ties vote 0
                for (int i = 0; i < 64; i++) begin
                    bi = 6'(i);
                    model_b[bi]   = (model_cnt[bi] > 0);
                    model_cnt[bi] = 0;
                end
            end
            hdc_pkg::op_store: begin
                stored   = model_b;
                is_store = 1'b1;
            end
            default: begin
            end
        endcase
        return is_store;
    endfunction

    // called one unit after a rising edge
    task automatic wb_write(input logic [15:0] word);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_dat_w = word;
        while (!wb_ack) begin
            if (waited >= timeout_cycles) fail_on_timeout("wb_ack");
            @(posedge clk);
            #1;
            waited++;
        end
        // hold the word through the ack cycle
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic issue(input logic [3:0] opc, input logic [5:0] field);
        logic [15:0] word;
        logic [63:0] stored;
        word = {opc, 6'b000000, field};
        if (hdc_model_step(word, stored)) begin
            expected_q.push_back(stored);
            stores_issued++;
        end
        wb_write(word);
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0) begin
            if (waited >= timeout_cycles) fail_on_timeout("all stored results");
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic wait_for_last();
        int waited;
        waited = 0;
        while (last_count == 0) begin
            if (waited >= timeout_cycles) fail_on_timeout("the last pulse");
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    // inputs are steady at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (result_valid && stalled) begin
                check_value("result_data held", result_data, held_data);
            end
            if (result_valid && result_ready) begin
                stalled = 1'b0;
                accepted_count++;
                if (expected_q.size() == 0) begin
                    $display("a result was accepted but no store was expected");
                    other_count++;
                end else begin
                    check_value("result_data", result_data, expected_q.pop_front());
                end
            end else if (result_valid) begin
                stalled   = 1'b1;
                held_data = result_data;
            end
            if (last) begin
                last_count++;
                if (expected_q.size() != 0 || result_valid) begin
                    $display("last pulse came before every store was accepted");
                    other_count++;
                end
            end
        end
    end

    initial begin
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_dat_w = '0;
        model_a  = '0;
        model_b  = '0;
        model_xs = hdc_pkg::xs_seed;
        for (int i = 0; i < 64; i++) model_cnt[i] = 0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("wb_ack", 64'(wb_ack), 64'd0);
        check_value("result_valid", 64'(result_valid), 64'd0);
        check_value("last", 64'(last), 64'd0);

        // generator fill, read back in order
        for (int i = 0; i < 8; i++) issue(hdc_pkg::op_gen, 6'(i));
        for (int i = 0; i < 8; i++) begin
            issue(hdc_pkg::op_load, 6'(i));
            issue(hdc_pkg::op_store, 6'd0);
        end

        // rotations, including the edge amounts
        issue(hdc_pkg::op_load, 6'd0);
        issue(hdc_pkg::op_perm, 6'd0);
        issue(hdc_pkg::op_store, 6'd0);
        issue(hdc_pkg::op_perm, 6'd1);
        issue(hdc_pkg::op_store, 6'd0);
        issue(hdc_pkg::op_perm, 6'd32);
        issue(hdc_pkg::op_store, 6'd0);
        issue(hdc_pkg::op_perm, 6'd63);
        issue(hdc_pkg::op_store, 6'd0);

        // bind, then write back and reload
        issue(hdc_pkg::op_load, 6'd1);
        issue(hdc_pkg::op_move, 6'd0);
        issue(hdc_pkg::op_load, 6'd2);
        issue(hdc_pkg::op_xor, 6'd0);
        issue(hdc_pkg::op_store, 6'd0);
        issue(hdc_pkg::op_wb, 6'd10);
        issue(hdc_pkg::op_load, 6'd3);
        issue(hdc_pkg::op_load, 6'd10);
        issue(hdc_pkg::op_store, 6'd0);

        // majority of three, then of four with ties
        for (int i = 0; i < 3; i++) begin
            issue(hdc_pkg::op_load, 6'(i));
            issue(hdc_pkg::op_bundle, 6'd0);
        end
        issue(hdc_pkg::op_sign, 6'd0);
        issue(hdc_pkg::op_store, 6'd0);
        for (int i = 3; i < 7; i++) begin
            issue(hdc_pkg::op_load, 6'(i));
            issue(hdc_pkg::op_bundle, 6'd0);
        end
        issue(hdc_pkg::op_sign, 6'd0);
        issue(hdc_pkg::op_store, 6'd0);

        // store burst against the random sink
        issue(hdc_pkg::op_load, 6'd4);
        for (int k = 0; k < 12; k++) begin
            issue(hdc_pkg::op_perm, 6'(k * 7 + 3));
            issue(hdc_pkg::op_store, 6'd0);
        end
        issue(hdc_pkg::op_last, 6'd0);

        wait_for_drain();
        wait_for_last();
        repeat (4) @(posedge clk);
        #1;
        check_value("last pulse count", 64'(last_count), 64'd1);
        check_value("results accepted", 64'(accepted_count), 64'(stores_issued));
        print_summary();
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sources.f
src/hdc_pkg.sv
src/hdc_decode.sv
src/hdc_item_memory.sv
src/hdc_execute.sv
src/hdc_result.sv
src/hdc_core.sv
dv/hdc_core_tb.sv

// File: Makefile
TB_TOP = hdc_core_tb

.PHONY: lint build sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module hdc_core
	verilator --lint-only --timing --assert -f sources.f --top-module $(TB_TOP)

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TB_TOP) \
		-o $(TB_TOP)_sim

sim: build
	./obj_dir/$(TB_TOP)_sim > sim.log 2>&1 || echo "Simulation failed" >> sim.log
	cat sim.log
	! grep -q "Simulation failed" sim.log

clean:
	rm -rf obj_dir sim.log
